//--- source/snes_bus_pkg.sv
package snes_bus_pkg;

  //////////////////////////////////////////////////
  // console bus widths

  typedef logic [23:0] snes_addr_t;  // full cpu address, bank included
  typedef logic [7:0]  snes_data_t;

  //////////////////////////////////////////////////
  // events and levels derived from the sampled bus

  // one cycle pulses, each from a fixed sample pattern
  typedef struct packed {
    logic rd_start;
    logic rd_end;
    logic wr_start;
    logic wr_end;
    logic cycle_start;  // cpu clock rising
    logic cycle_end;    // cpu clock falling
  } snes_strobes_t;

  // filtered lines, still active low
  typedef struct packed {
    logic read;
    logic write;
    logic cpu_clk;
    logic romsel;
  } snes_levels_t;

endpackage

//--- source/rom_mem_pkg.sv
package rom_mem_pkg;

  //////////////////////////////////////////////////
  // rom / psram side

  typedef logic [22:0] rom_addr_t;  // word address
  typedef logic [15:0] rom_word_t;
  typedef logic [3:0]  cycle_cnt_t;

  // request as given by the mcu or dma port
  typedef struct packed {
    snes_bus_pkg::snes_addr_t addr;  // byte address
    rom_word_t                data;
    logic                     word;  // dma only, both lanes
    logic                     rrq;
    logic                     wrq;
  } mem_req_t;

  // everything that goes out to the memory chip
  typedef struct packed {
    rom_addr_t addr;
    rom_word_t dout;
    logic      dout_oe;
    logic      we_n;
    logic      bhe_n;
    logic      ble_n;
  } rom_bus_t;

  typedef enum logic [1:0] {st_idle, st_access, st_end} arb_state_t;

  typedef enum logic [2:0] {own_snes, own_mcu_rd, own_mcu_wr, own_dma_rd, own_dma_wr} mem_owner_t;

endpackage

//--- source/snes_bus_sync.sv
module snes_bus_sync #(
  parameter int unsigned DEAD_TIMEOUT = 96000
) (
  input  logic                        CLK2,
  input  logic                        SNES_reset_strobe,
  input  snes_bus_pkg::snes_addr_t    snes_addr_in,
  input  logic                        snes_read_in,
  input  logic                        snes_write_in,
  input  logic                        snes_romsel_in,
  input  logic                        snes_cpu_clk_in,
  output snes_bus_pkg::snes_addr_t    snes_addr,
  output snes_bus_pkg::snes_strobes_t strobes,
  output snes_bus_pkg::snes_levels_t  levels,
  output logic                        snes_dead
);

  // counter tops out one above the timeout
  localparam int unsigned CNT_W = $clog2(DEAD_TIMEOUT + 2);

  logic [6:0]               read_sr;     // bit 0 newest sample
  logic [6:0]               write_sr;
  logic [6:0]               romsel_sr;
  logic [6:0]               cpu_clk_sr;
  snes_bus_pkg::snes_addr_t addr_sr [0:5];  // taps at 5 and 4
  logic [CNT_W-1:0]         dead_cnt;

  //////////////////////////////////////////////////
  // input sampling

  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      read_sr    <= '1;  // control lines idle high
      write_sr   <= '1;
      romsel_sr  <= '1;
      cpu_clk_sr <= '0;
    end else begin
      read_sr    <= {read_sr[5:0], snes_read_in};
      write_sr   <= {write_sr[5:0], snes_write_in};
      romsel_sr  <= {romsel_sr[5:0], snes_romsel_in};
      cpu_clk_sr <= {cpu_clk_sr[5:0], snes_cpu_clk_in};
    end
  end

  always_ff @(posedge CLK2) begin
    addr_sr[0] <= snes_addr_in;
    for (int i = 1; i < 6; i++) begin
      addr_sr[i] <= addr_sr[i-1];
    end
  end

  // two stages must agree before a bit counts as one
  assign snes_addr = addr_sr[5] & addr_sr[4];

  //////////////////////////////////////////////////
  // strobes and levels

  always_comb begin
    strobes.rd_start    = (read_sr[6:1] == 6'b111110);
    strobes.rd_end      = (read_sr[6:1] == 6'b000001);
    strobes.wr_start    = (write_sr[6:1] == 6'b111000);  // later than rd, data settles
    strobes.wr_end      = (write_sr[6:1] == 6'b000001);
    strobes.cycle_start = (cpu_clk_sr[6:1] == 6'b000001);
    strobes.cycle_end   = (cpu_clk_sr[6:1] == 6'b111110);

    levels.read    = read_sr[2] & read_sr[1];
    levels.write   = write_sr[2] & write_sr[1];
    levels.cpu_clk = cpu_clk_sr[2] & cpu_clk_sr[1];
    levels.romsel  = romsel_sr[2] & romsel_sr[1];
  end

  //////////////////////////////////////////////////
  // dead console detection

  // cpu clock stuck low means no console, or one held in reset
  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      dead_cnt  <= '0;
      snes_dead <= 1'b0;
    end else if (cpu_clk_sr[1]) begin
      dead_cnt  <= '0;
      snes_dead <= 1'b0;  // first high sample revives
    end else begin
      if (dead_cnt <= CNT_W'(DEAD_TIMEOUT)) begin
        dead_cnt <= dead_cnt + 1'b1;  // saturates
      end
      if (dead_cnt > CNT_W'(DEAD_TIMEOUT)) begin
        snes_dead <= 1'b1;
      end
    end
  end

endmodule

//--- source/rom_cycle_timer.sv
module rom_cycle_timer #(
  parameter int unsigned ROM_CYCLE_LEN = 7
) (
  input  logic CLK2,
  input  logic SNES_reset_strobe,
  input  logic grant,
  output logic cycle_done
);

  rom_mem_pkg::cycle_cnt_t cnt;

  // counts the wait for the psram to settle
  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      cnt <= '0;
    end else if (grant) begin
      cnt <= rom_mem_pkg::cycle_cnt_t'(ROM_CYCLE_LEN);
    end else if (cnt != '0) begin
      cnt <= cnt - 1'b1;  // parks at zero
    end
  end

  // high in idle too, fsm only looks at it during an access
  assign cycle_done = (cnt == '0);

endmodule

//--- source/rom_arbiter_fsm.sv
module rom_arbiter_fsm (
  input  logic                        CLK2,
  input  logic                        SNES_reset_strobe,
  input  snes_bus_pkg::snes_strobes_t strobes,
  input  snes_bus_pkg::snes_levels_t  levels,
  input  logic                        snes_dead,
  input  logic                        mcu_rd_pend,
  input  logic                        mcu_wr_pend,
  input  logic                        dma_rd_pend,
  input  logic                        dma_wr_pend,
  input  logic                        cycle_done,
  output rom_mem_pkg::arb_state_t     state,
  output rom_mem_pkg::mem_owner_t     owner,
  output logic                        grant
);

  logic                    free_strobe;
  logic                    free_slot;
  logic                    any_pend;
  rom_mem_pkg::mem_owner_t next_owner;

  //////////////////////////////////////////////////
  // free slot detection

  // second chance per cpu cycle when romsel stays high
  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= strobes.cycle_start & levels.romsel;
    end
  end

  assign free_slot = strobes.cycle_end | free_strobe;  // console done with the bus

  //////////////////////////////////////////////////
  // requester selection

  assign any_pend = mcu_rd_pend | mcu_wr_pend | dma_rd_pend | dma_wr_pend;

  // fixed priority, mcu before dma, read before write
  always_comb begin
    if (mcu_rd_pend) begin
      next_owner = rom_mem_pkg::own_mcu_rd;
    end else if (mcu_wr_pend) begin
      next_owner = rom_mem_pkg::own_mcu_wr;
    end else if (dma_rd_pend) begin
      next_owner = rom_mem_pkg::own_dma_rd;
    end else begin
      next_owner = rom_mem_pkg::own_dma_wr;
    end
  end

  // a dead console never claims the bus, so no slot is needed then
  assign grant = (state == rom_mem_pkg::st_idle) & any_pend & (free_slot | snes_dead);

  //////////////////////////////////////////////////
  // access sequencing

  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      state <= rom_mem_pkg::st_idle;
      owner <= rom_mem_pkg::own_snes;
    end else begin
      case (state)
        rom_mem_pkg::st_idle: begin
          if (grant) begin
            state <= rom_mem_pkg::st_access;
            owner <= next_owner;
          end
        end
        rom_mem_pkg::st_access: begin
          if (cycle_done) begin
            state <= rom_mem_pkg::st_end;  // timer ran out
          end
        end
        rom_mem_pkg::st_end: begin
          state <= rom_mem_pkg::st_idle;
          owner <= rom_mem_pkg::own_snes;  // address back to the console
        end
        default: begin
          state <= rom_mem_pkg::st_idle;
          owner <= rom_mem_pkg::own_snes;
        end
      endcase
    end
  end

endmodule

//--- source/rom_request_regs.sv
module rom_request_regs (
  input  logic                     CLK2,
  input  logic                     SNES_reset_strobe,
  input  rom_mem_pkg::mem_req_t    mcu_req,
  input  rom_mem_pkg::mem_req_t    dma_req,
  input  rom_mem_pkg::arb_state_t  state,
  input  rom_mem_pkg::mem_owner_t  owner,
  input  rom_mem_pkg::rom_word_t   rom_din,
  output logic                     mcu_rd_pend,
  output logic                     mcu_wr_pend,
  output logic                     dma_rd_pend,
  output logic                     dma_wr_pend,
  output logic                     mcu_rdy,
  output logic                     dma_rdy,
  output rom_mem_pkg::mem_req_t    mcu_held,
  output rom_mem_pkg::mem_req_t    dma_held,
  output snes_bus_pkg::snes_data_t mcu_din,
  output rom_mem_pkg::rom_word_t   dma_din
);

  logic mcu_done;
  logic dma_done;

  assign mcu_done = (state == rom_mem_pkg::st_end) &
                    ((owner == rom_mem_pkg::own_mcu_rd) | (owner == rom_mem_pkg::own_mcu_wr));
  assign dma_done = (state == rom_mem_pkg::st_end) &
                    ((owner == rom_mem_pkg::own_dma_rd) | (owner == rom_mem_pkg::own_dma_wr));

  //////////////////////////////////////////////////
  // pending flags and ready

  // a pulse wins over the end of the previous access
  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      mcu_rd_pend <= 1'b0;
      mcu_wr_pend <= 1'b0;
      dma_rd_pend <= 1'b0;
      dma_wr_pend <= 1'b0;
      mcu_rdy     <= 1'b1;
      dma_rdy     <= 1'b1;
    end else begin
      if (mcu_req.rrq) begin
        mcu_rd_pend <= 1'b1;
        mcu_rdy     <= 1'b0;
      end else if (mcu_req.wrq) begin
        mcu_wr_pend <= 1'b1;
        mcu_rdy     <= 1'b0;
      end else if (mcu_done) begin
        mcu_rd_pend <= 1'b0;
        mcu_wr_pend <= 1'b0;
        mcu_rdy     <= 1'b1;
      end

      if (dma_req.rrq) begin
        dma_rd_pend <= 1'b1;
        dma_rdy     <= 1'b0;
      end else if (dma_req.wrq) begin
        dma_wr_pend <= 1'b1;
        dma_rdy     <= 1'b0;
      end else if (dma_done) begin
        dma_rd_pend <= 1'b0;
        dma_wr_pend <= 1'b0;
        dma_rdy     <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // request payload and read data

  always_ff @(posedge CLK2) begin
    if (mcu_req.rrq | mcu_req.wrq) begin
      mcu_held <= mcu_req;
    end
    if (dma_req.rrq | dma_req.wrq) begin
      dma_held <= dma_req;
    end
    // sampled every access cycle, last one is kept
    if ((state == rom_mem_pkg::st_access) & (owner == rom_mem_pkg::own_mcu_rd)) begin
      mcu_din <= mcu_held.addr[0] ? rom_din[7:0] : rom_din[15:8];
    end
    if ((state == rom_mem_pkg::st_access) & (owner == rom_mem_pkg::own_dma_rd)) begin
      dma_din <= dma_held.addr[0] ? rom_din :
                 {rom_din[7:0], rom_din[15:8]};  // even address comes back swapped
    end
  end

endmodule

//--- source/rom_port_mux.sv
module rom_port_mux (
  input  snes_bus_pkg::snes_addr_t snes_addr,
  input  rom_mem_pkg::mem_owner_t  owner,
  input  rom_mem_pkg::arb_state_t  state,
  input  rom_mem_pkg::mem_req_t    mcu_held,
  input  rom_mem_pkg::mem_req_t    dma_held,
  output rom_mem_pkg::rom_bus_t    rom_bus
);

  snes_bus_pkg::snes_addr_t sel_addr;
  rom_mem_pkg::rom_word_t   sel_data;
  logic                     both_lanes;
  logic                     wr_access;

  //////////////////////////////////////////////////
  // source select

  always_comb begin
    case (owner)
      rom_mem_pkg::own_mcu_rd,
      rom_mem_pkg::own_mcu_wr: begin
        sel_addr   = mcu_held.addr;
        sel_data   = {mcu_held.data[7:0], mcu_held.data[7:0]};  // byte on both lanes
        both_lanes = 1'b0;
      end
      rom_mem_pkg::own_dma_rd,
      rom_mem_pkg::own_dma_wr: begin
        sel_addr   = dma_held.addr;
        sel_data   = {dma_held.data[7:0], dma_held.data[15:8]};
        both_lanes = dma_held.word;
      end
      default: begin
        // console address passes straight through
        sel_addr   = snes_addr;
        sel_data   = '0;
        both_lanes = 1'b0;
      end
    endcase
  end

  // write strobe only while the access itself runs
  assign wr_access = (state == rom_mem_pkg::st_access) &
                     ((owner == rom_mem_pkg::own_mcu_wr) | (owner == rom_mem_pkg::own_dma_wr));

  //////////////////////////////////////////////////
  // memory pins

  always_comb begin
    rom_bus.addr    = sel_addr[23:1];
    rom_bus.dout    = sel_data;
    rom_bus.dout_oe = wr_access;
    rom_bus.we_n    = ~wr_access;
    rom_bus.bhe_n   = sel_addr[0];                 // even byte sits on the high lane
    rom_bus.ble_n   = ~(sel_addr[0] | both_lanes);
  end

endmodule

//--- source/mem_ctrl_top.sv
module mem_ctrl_top #(
  parameter int unsigned DEAD_TIMEOUT  = 96000,  // about 1 ms at the core clock
  parameter int unsigned ROM_CYCLE_LEN = 7
) (
  input  logic                     CLK2,
  input  logic                     SNES_reset_strobe,
  input  snes_bus_pkg::snes_addr_t snes_addr_in,
  input  logic                     snes_read_in,
  input  logic                     snes_write_in,
  input  logic                     snes_romsel_in,
  input  logic                     snes_cpu_clk_in,
  input  rom_mem_pkg::mem_req_t    mcu_req,
  input  rom_mem_pkg::mem_req_t    dma_req,
  input  rom_mem_pkg::rom_word_t   rom_din,
  output rom_mem_pkg::rom_bus_t    rom_bus,
  output logic                     mcu_rdy,
  output snes_bus_pkg::snes_data_t mcu_din,
  output logic                     dma_rdy,
  output rom_mem_pkg::rom_word_t   dma_din,
  output logic                     snes_dead
);

  snes_bus_pkg::snes_addr_t    snes_addr;
  snes_bus_pkg::snes_strobes_t strobes;
  snes_bus_pkg::snes_levels_t  levels;
  rom_mem_pkg::arb_state_t     state;
  rom_mem_pkg::mem_owner_t     owner;
  rom_mem_pkg::mem_req_t       mcu_held;
  rom_mem_pkg::mem_req_t       dma_held;
  logic                        grant;
  logic                        cycle_done;
  logic                        mcu_rd_pend;
  logic                        mcu_wr_pend;
  logic                        dma_rd_pend;
  logic                        dma_wr_pend;

  snes_bus_sync #(.DEAD_TIMEOUT(DEAD_TIMEOUT)) bus_sync0 (
    .CLK2, .SNES_reset_strobe, .snes_addr_in, .snes_read_in, .snes_write_in,
    .snes_romsel_in, .snes_cpu_clk_in, .snes_addr, .strobes, .levels, .snes_dead
  );

  rom_cycle_timer #(.ROM_CYCLE_LEN(ROM_CYCLE_LEN)) cycle_timer0 (
    .CLK2, .SNES_reset_strobe, .grant, .cycle_done
  );

  rom_arbiter_fsm arbiter0 (
    .CLK2, .SNES_reset_strobe, .strobes, .levels, .snes_dead, .mcu_rd_pend,
    .mcu_wr_pend, .dma_rd_pend, .dma_wr_pend, .cycle_done, .state, .owner, .grant
  );

  rom_request_regs request_regs0 (
    .CLK2, .SNES_reset_strobe, .mcu_req, .dma_req, .state, .owner, .rom_din,
    .mcu_rd_pend, .mcu_wr_pend, .dma_rd_pend, .dma_wr_pend, .mcu_rdy, .dma_rdy,
    .mcu_held, .dma_held, .mcu_din, .dma_din
  );

  rom_port_mux port_mux0 (
    .snes_addr, .owner, .state, .mcu_held, .dma_held, .rom_bus
  );

endmodule

//--- testbench/mem_ctrl_props.sv
module mem_ctrl_props #(
  parameter int unsigned ROM_CYCLE_LEN = 7
) (
  input logic                    CLK2,
  input logic                    SNES_reset_strobe,
  input rom_mem_pkg::arb_state_t state,
  input rom_mem_pkg::mem_owner_t owner,
  input logic                    grant,
  input logic                    cycle_done,
  input logic                    we_n
);

  logic fail_seen = 1'b0;

  // grants only leave the idle state, with the bus back at the console and the timer run down
  a_grant_idle: assert property (@(posedge CLK2) disable iff (SNES_reset_strobe)
    grant |-> (state == rom_mem_pkg::st_idle) && (owner == rom_mem_pkg::own_snes) && cycle_done)
    else begin
      fail_seen = 1'b1;
      $error("grant outside idle");
    end

  // write strobe opens only right after a write grant
  a_we_open: assert property (@(posedge CLK2) disable iff (SNES_reset_strobe)
    $fell(we_n) |-> $past(grant) &&
                    (owner == rom_mem_pkg::own_mcu_wr || owner == rom_mem_pkg::own_dma_wr))
    else begin
      fail_seen = 1'b1;
      $error("we_n fell without a write grant");
    end

  // and closes as the access ends
  a_we_close: assert property (@(posedge CLK2) disable iff (SNES_reset_strobe)
    $rose(we_n) |-> (state == rom_mem_pkg::st_end))
    else begin
      fail_seen = 1'b1;
      $error("we_n rose outside the end of an access");
    end

  a_access_len: assert property (@(posedge CLK2) disable iff (SNES_reset_strobe)
    grant |=> (state == rom_mem_pkg::st_access) [*ROM_CYCLE_LEN+1]
              ##1 (state == rom_mem_pkg::st_end))
    else begin
      fail_seen = 1'b1;
      $error("access length wrong");
    end

endmodule

// arbiter and mux signals are all visible at the top level
bind mem_ctrl_top mem_ctrl_props #(.ROM_CYCLE_LEN(ROM_CYCLE_LEN)) props0 (
  .CLK2, .SNES_reset_strobe, .state, .owner, .grant, .cycle_done, .we_n(rom_bus.we_n)
);

//--- testbench/tb_mem_ctrl.sv
module tb_mem_ctrl;

  localparam int unsigned DEAD_TIMEOUT = 200;
  localparam int unsigned N_PAIR       = 16;  // writes then reads, per port
  localparam int unsigned NUM_REQ      = 4 * N_PAIR + 4 + 8;
  localparam int unsigned WATCH_CYCLES = NUM_REQ * (DEAD_TIMEOUT + 40);

  logic                     CLK2;
  logic                     SNES_reset_strobe;
  snes_bus_pkg::snes_addr_t snes_addr_in;
  logic                     snes_read_in, snes_write_in, snes_romsel_in, snes_cpu_clk_in;
  rom_mem_pkg::mem_req_t    mcu_req, dma_req;
  rom_mem_pkg::rom_word_t   rom_din;
  rom_mem_pkg::rom_bus_t    rom_bus;
  logic                     mcu_rdy, dma_rdy, snes_dead;
  snes_bus_pkg::snes_data_t mcu_din;
  rom_mem_pkg::rom_word_t   dma_din;

  integer          seed = 32'h6d79;
  logic [15:0]     rom_mem [int];  // memory chip contents
  logic [15:0]     shadow [int];   // expected contents
  logic [23:0]     addr_list [0:N_PAIR-1];
  logic            hold_low;
  logic [6:0]      clk_hist, rs_hist;
  logic            free_q;
  snes_bus_pkg::snes_addr_t prev_addr;
  int              addr_age;

  mem_ctrl_top #(.DEAD_TIMEOUT(DEAD_TIMEOUT), .ROM_CYCLE_LEN(7)) dut0 (.*);

  always #20 CLK2 = ~CLK2;

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic logic [15:0] fill_word(input logic [22:0] a);
    return a[15:0] ^ {a[22:16], a[22:16], 2'b01};
  endfunction

  function automatic logic [15:0] shadow_get(input logic [22:0] a);
    return shadow.exists(int'(a)) ? shadow[int'(a)] : fill_word(a);
  endfunction

  // lane enables follow the byte address, data lanes are crossed
  function automatic void shadow_write(input logic [23:0] a, input logic [15:0] lanes,
                                       input logic lo_extra);
    logic [15:0] w;
    w = shadow_get(a[23:1]);
    if (!a[0]) w[15:8] = lanes[15:8];
    if (a[0] | lo_extra) w[7:0] = lanes[7:0];
    shadow[int'(a[23:1])] = w;
  endfunction

  ////////////////////////////////////////////////// memory and console models

  always @(negedge CLK2) begin
    rom_din <= rom_mem.exists(int'(rom_bus.addr)) ? rom_mem[int'(rom_bus.addr)]
                                                  : fill_word(rom_bus.addr);
  end

  always @(posedge CLK2) begin
    logic [15:0] w;
    if (!rom_bus.we_n) begin
      check_value("dout_oe during write", rom_bus.dout_oe, 1);
      w = rom_mem.exists(int'(rom_bus.addr)) ? rom_mem[int'(rom_bus.addr)]
                                             : fill_word(rom_bus.addr);
      if (!rom_bus.bhe_n) w[15:8] = rom_bus.dout[15:8];
      if (!rom_bus.ble_n) w[7:0] = rom_bus.dout[7:0];
      rom_mem[int'(rom_bus.addr)] = w;
    end
  end

  initial begin : console_model
    int unsigned r;
    @(negedge SNES_reset_strobe);
    forever begin
      r = $random(seed);
      repeat (6 + r % 5) @(posedge CLK2);  // half period 6..10
      r = $random(seed);
      snes_cpu_clk_in <= hold_low ? 1'b0 : ~snes_cpu_clk_in;
      snes_romsel_in  <= r[0];
      if (r[3:1] == 3'd0) snes_addr_in <= {r[31:8]};
    end
  end

  ////////////////////////////////////////////////// monitors

  // own copy of the sampled console lines
  always @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      clk_hist <= '0;
      rs_hist  <= '1;
      free_q   <= 1'b0;
    end else begin
      clk_hist <= {clk_hist[5:0], snes_cpu_clk_in};
      rs_hist  <= {rs_hist[5:0], snes_romsel_in};
      free_q   <= (clk_hist[6:1] == 6'b000001) & rs_hist[2] & rs_hist[1];
    end
    prev_addr <= snes_addr_in;
    addr_age  <= (snes_addr_in == prev_addr) ? ((addr_age < 100) ? addr_age + 1 : addr_age) : 0;
  end

  always @(negedge CLK2) begin
    if (!SNES_reset_strobe) begin
      if (dut0.arbiter0.grant && !snes_dead)
        check_value("grant without free slot", (clk_hist[6:1] == 6'b111110) | free_q, 1);
      if (mcu_rdy && dma_rdy && addr_age >= 7)
        check_value("console address", rom_bus.addr, prev_addr[23:1]);
    end
  end

  initial begin : watchdog
    repeat (WATCH_CYCLES) @(posedge CLK2);
    $display("timeout, a request was never answered");
    $display("*** TEST FAILED ***");
    $fatal(1, "watchdog");
  end

  ////////////////////////////////////////////////// request helpers

  task automatic start_req(input bit dma, input bit wr, input logic [23:0] a,
                           input logic [15:0] d, input bit word);
    if (dma) begin
      dma_req <= '{addr: a, data: d, word: word, rrq: !wr, wrq: wr};
    end else begin
      mcu_req <= '{addr: a, data: d, word: 1'b0, rrq: !wr, wrq: wr};
    end
  endtask

  task automatic clear_pulses();
    mcu_req.rrq <= 1'b0;
    mcu_req.wrq <= 1'b0;
    dma_req.rrq <= 1'b0;
    dma_req.wrq <= 1'b0;
  endtask

  task automatic do_access(input bit dma, input bit wr, input logic [23:0] a,
                           input logic [15:0] d, input bit word);
    @(posedge CLK2);
    start_req(dma, wr, a, d, word);
    @(posedge CLK2);
    clear_pulses();
    do @(negedge CLK2); while (!(dma ? dma_rdy : mcu_rdy));
    if (wr && dma) shadow_write(a, {d[7:0], d[15:8]}, word);
    if (wr && !dma) shadow_write(a, {d[7:0], d[7:0]}, 1'b0);
  endtask

  task automatic read_check(input bit dma, input logic [23:0] a);
    logic [15:0] w;
    do_access(dma, 1'b0, a, 16'h0, 1'b0);
    w = shadow_get(a[23:1]);
    if (dma) check_value("dma read", dma_din, a[0] ? w : {w[7:0], w[15:8]});
    else check_value("mcu read", mcu_din, a[0] ? w[7:0] : w[15:8]);
  endtask

  ////////////////////////////////////////////////// main sequence

  initial begin
    int unsigned r;
    CLK2 = 0;
    SNES_reset_strobe = 1;
    snes_addr_in = 24'h123456;
    {snes_read_in, snes_write_in, snes_romsel_in, snes_cpu_clk_in} = 4'b1110;
    mcu_req = '0;
    dma_req = '0;
    rom_din = '0;
    hold_low = 0;
    prev_addr = '0;
    addr_age = 0;
    repeat (5) @(posedge CLK2);
    SNES_reset_strobe <= 0;
    @(negedge CLK2);
    check_value("mcu_rdy after reset", mcu_rdy, 1);
    check_value("dma_rdy after reset", dma_rdy, 1);
    check_value("we_n after reset", rom_bus.we_n, 1);
    check_value("dout_oe after reset", rom_bus.dout_oe, 0);

    for (int p = 0; p < 2; p++) begin  // mcu bytes, then dma
      for (int i = 0; i < N_PAIR; i++) begin
        r = $random(seed);
        addr_list[i] = {16'h0, r[7:0]};
        do_access(p == 1, 1'b1, addr_list[i], r[31:16], r[8]);
      end
      for (int i = 0; i < N_PAIR; i++) read_check(p == 1, addr_list[i]);
    end

    // dead console, no slots needed
    hold_low = 1;
    do @(negedge CLK2); while (!snes_dead);
    r = $random(seed);
    do_access(1'b0, 1'b1, 24'h000040, r[15:0], 1'b0);
    do_access(1'b1, 1'b1, 24'h000042, r[31:16], 1'b1);
    read_check(1'b0, 24'h000040);
    read_check(1'b1, 24'h000042);
    hold_low = 0;
    do @(negedge CLK2); while (snes_dead);

    // both ports at once, mcu served first
    for (int i = 0; i < 4; i++) begin
      r = $random(seed);
      @(posedge CLK2);
      start_req(1'b0, 1'b1, {16'h0, r[7:0]}, r[31:16], 1'b0);
      start_req(1'b1, 1'b1, {16'h1, r[15:8]}, r[31:16], 1'b1);
      @(posedge CLK2);
      clear_pulses();
      do @(negedge CLK2); while (!mcu_rdy);
      check_value("dma finished before mcu", dma_rdy, 0);
      do @(negedge CLK2); while (!dma_rdy);
      shadow_write({16'h0, r[7:0]}, {r[23:16], r[23:16]}, 1'b0);
      shadow_write({16'h1, r[15:8]}, {r[23:16], r[31:24]}, 1'b1);
    end

    if (dut0.props0.fail_seen) begin
      $display("a bound assertion on the arbiter or the write strobe failed");
      $display("*** TEST FAILED ***");
      $fatal(1, "assertion failure");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

//--- filelist.f
source/snes_bus_pkg.sv
source/rom_mem_pkg.sv
source/snes_bus_sync.sv
source/rom_cycle_timer.sv
source/rom_arbiter_fsm.sv
source/rom_request_regs.sv
source/rom_port_mux.sv
source/mem_ctrl_top.sv
testbench/mem_ctrl_props.sv
testbench/tb_mem_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, pass is decided from the log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_ctrl \
  -f filelist.f -o tb_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
grep -q "\*\*\* TEST PASSED \*\*\*" sim.log && echo "simulation passed" || {
  echo "simulation failed, see sim.log"; exit 1; }
